// File: rtl/sram_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types and helpers for the SRAM self-test subsystem
// state encodings for the port controller and the test engines, plus
// the data pattern rule that the engines and the testbench both use
////////////////////////////////////////////////////////////////////////////

package sram_pkg;

   // widest word the pattern rule works on; callers truncate to DATA_W
   localparam int PAT_W = 64;

   typedef enum logic [2:0] {
      arb_idle      = 3'd0,
      arb_addr      = 3'd1,
      arb_wait      = 3'd2,
      arb_wait_flip = 3'd3,  // read turnaround
      arb_data      = 3'd4,
      arb_done      = 3'd5
   } arb_state_t;

   typedef enum logic [1:0] {
      eng_idle   = 2'd0,
      eng_write  = 2'd1,
      eng_read   = 2'd2,
      eng_finish = 2'd3
   } eng_state_t;

   // expected word: seed plus zero-extended address
   function automatic logic [PAT_W-1:0] pattern_word(input logic [PAT_W-1:0] seed,
                                                     input logic [PAT_W-1:0] addr);
      return seed + addr;
   endfunction

endpackage

// File: rtl/sram_req_if.sv
////////////////////////////////////////////////////////////////////////////
// request/acknowledge link between one test engine and the SRAM controller
// requester holds req and its payload until ack, ack is a single-cycle
// pulse, read data is valid in the ack cycle and held afterwards
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface sram_req_if #(
   parameter int ADDR_W = 19,
   parameter int DATA_W = 36
);

   logic              req;
   logic              rd;       // 1 = read, 0 = write
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wr_data;
   logic              ack;
   logic [DATA_W-1:0] rd_data;

   // test engine side
   modport requester (
      output req,
      output rd,
      output addr,
      output wr_data,
      input  ack,
      input  rd_data
   );

   // controller side
   modport server (
      input  req,
      input  rd,
      input  addr,
      input  wr_data,
      output ack,
      output rd_data
   );

endinterface

// File: rtl/sram_port_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// two-port round-robin controller for a synchronous SRAM with two clocks
// from address to data; serves one request at a time, adds a turnaround
// cycle on reads and pulses ack on the port it served
// all SRAM pins come straight from flops
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_port_arbiter #(
   parameter int ADDR_W = 19,
   parameter int DATA_W = 36
) (
   input  logic               clk,
   input  logic               reset,

   sram_req_if.server         port0,
   sram_req_if.server         port1,

   output logic [ADDR_W-1:0]  sram_addr,
   output logic [DATA_W-1:0]  sram_wr_data,
   input  logic [DATA_W-1:0]  sram_rd_data,
   output logic               sram_tri_en,
   output logic               sram_we_bw
);

   import sram_pkg::*;

   arb_state_t        state, state_nxt;
   logic              cur_port, cur_port_nxt;  // port being served or polled
   logic              rd_q, rd_nxt;            // latched direction of request

   logic [ADDR_W-1:0] addr_nxt;
   logic [DATA_W-1:0] wr_data_nxt;
   logic              tri_en_nxt;
   logic              we_bw_nxt;
   logic              ack_0_nxt, ack_1_nxt;

   logic [DATA_W-1:0] sram_rd_data_d;  // read data retimed into our domain

   logic              req_cur;
   logic              rd_cur;
   logic [ADDR_W-1:0] addr_cur;
   logic [DATA_W-1:0] wr_data_cur;

   ////////////////////////////////////////////////////////////////////////////
   // current port select

   assign req_cur     = cur_port ? port1.req     : port0.req;
   assign rd_cur      = cur_port ? port1.rd      : port0.rd;
   assign addr_cur    = cur_port ? port1.addr    : port0.addr;
   assign wr_data_cur = cur_port ? port1.wr_data : port0.wr_data;

   ////////////////////////////////////////////////////////////////////////////
   // next state

   always_comb begin
      state_nxt    = state;
      cur_port_nxt = cur_port;
      rd_nxt       = rd_q;
      addr_nxt     = sram_addr;
      wr_data_nxt  = sram_wr_data;
      tri_en_nxt   = 1'b0;   // drive bus for one cycle only
      we_bw_nxt    = 1'b1;   // write strobe is active low
      ack_0_nxt    = 1'b0;
      ack_1_nxt    = 1'b0;

      case (state)
         arb_idle: begin
            if (req_cur) begin
               addr_nxt  = addr_cur;
               we_bw_nxt = rd_cur;
               rd_nxt    = rd_cur;
               state_nxt = arb_addr;
            end else begin
               cur_port_nxt = ~cur_port;  // nothing here, poll the other port
            end
         end

         arb_addr: state_nxt = arb_wait;

         arb_wait: begin
            if (rd_q) begin
               state_nxt = arb_wait_flip;
            end else begin
               // write data lands two clocks after the address
               tri_en_nxt  = 1'b1;
               wr_data_nxt = wr_data_cur;
               state_nxt   = arb_data;
            end
         end

         arb_wait_flip: state_nxt = arb_data;

         arb_data: begin
            ack_0_nxt    = ~cur_port;
            ack_1_nxt    = cur_port;
            cur_port_nxt = ~cur_port;  // strict alternation under load
            state_nxt    = arb_done;
         end

         // requester updates its request here, idle samples it next cycle
         arb_done: state_nxt = arb_idle;

         default: state_nxt = arb_idle;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // registers

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= arb_idle;
         cur_port     <= 1'b0;   // port 0 goes first
         rd_q         <= 1'b1;
         sram_addr    <= '0;
         sram_wr_data <= '0;
         sram_tri_en  <= 1'b0;
         sram_we_bw   <= 1'b1;
         port0.ack    <= 1'b0;
         port1.ack    <= 1'b0;
      end else begin
         state        <= state_nxt;
         cur_port     <= cur_port_nxt;
         rd_q         <= rd_nxt;
         sram_addr    <= addr_nxt;
         sram_wr_data <= wr_data_nxt;
         sram_tri_en  <= tri_en_nxt;
         sram_we_bw   <= we_bw_nxt;
         port0.ack    <= ack_0_nxt;
         port1.ack    <= ack_1_nxt;
      end
   end

   // read return path, data held until the next read on that port
   always_ff @(posedge clk) begin
      sram_rd_data_d <= sram_rd_data;
      if (state == arb_data && rd_q) begin
         if (cur_port)
            port1.rd_data <= sram_rd_data_d;
         else
            port0.rd_data <= sram_rd_data_d;
      end
   end

endmodule

// File: rtl/sram_test_engine.sv
////////////////////////////////////////////////////////////////////////////
// write-then-verify pattern engine for one SRAM address region
// on start it writes the pattern over base..base+len-1, reads the region
// back, counts words that differ and raises done until the next start
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_test_engine #(
   parameter int ADDR_W = 19,
   parameter int DATA_W = 36
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              start,

   input  logic [ADDR_W-1:0] base,
   input  logic [ADDR_W-1:0] len,
   input  logic [DATA_W-1:0] seed,

   sram_req_if.requester     bus,

   output logic              done,
   output logic [ADDR_W-1:0] err_count
);

   import sram_pkg::*;

   eng_state_t        state;
   logic [ADDR_W-1:0] cnt;       // word index inside the region

   // region settings, latched at start
   logic [ADDR_W-1:0] base_r;
   logic [ADDR_W-1:0] len_r;
   logic [DATA_W-1:0] seed_r;

   logic              start_ok;
   logic              last;
   logic [ADDR_W-1:0] cur_addr;
   logic [DATA_W-1:0] expected;
   logic              mismatch;

   assign start_ok = start && (state == eng_idle || state == eng_finish);
   assign last     = (cnt == len_r - 1'b1);
   assign cur_addr = base_r + cnt;
   assign expected = DATA_W'(pattern_word(PAT_W'(seed_r), PAT_W'(cur_addr)));
   assign mismatch = (bus.rd_data != expected);

   ////////////////////////////////////////////////////////////////////////////
   // request outputs, stable while waiting since they come from flops

   assign bus.req     = (state == eng_write) || (state == eng_read);
   assign bus.rd      = (state == eng_read);
   assign bus.addr    = cur_addr;
   assign bus.wr_data = expected;  // same word is written and later checked

   ////////////////////////////////////////////////////////////////////////////
   // control FSM

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= eng_idle;
         cnt       <= '0;
         done      <= 1'b0;
         err_count <= '0;
      end else begin
         case (state)
            eng_idle, eng_finish: begin
               if (start_ok) begin
                  cnt       <= '0;
                  err_count <= '0;
                  done      <= (len == '0);  // empty region finishes at once
                  state     <= (len == '0) ? eng_finish : eng_write;
               end
            end

            eng_write: begin
               if (bus.ack) begin
                  if (last) begin
                     cnt   <= '0;
                     state <= eng_read;    // go back over the region
                  end else begin
                     cnt <= cnt + 1'b1;
                  end
               end
            end

            eng_read: begin
               if (bus.ack) begin
                  if (mismatch)
                     err_count <= err_count + 1'b1;
                  if (last) begin
                     done  <= 1'b1;
                     state <= eng_finish;
                  end else begin
                     cnt <= cnt + 1'b1;
                  end
               end
            end

            default: state <= eng_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start_ok) begin
         base_r <= base;
         len_r  <= len;
         seed_r <= seed;
      end
   end

endmodule

// File: rtl/sram_selftest_top.sv
////////////////////////////////////////////////////////////////////////////
// SRAM self-test top level
// two pattern engines share one SRAM through the round-robin controller;
// a single start runs both, each reports its own done and error count
// the SRAM pins are split, pad logic sits outside
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_selftest_top #(
   parameter int ADDR_W = 19,
   parameter int DATA_W = 36
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              start,

   // engine 0 region
   input  logic [ADDR_W-1:0] base_0,
   input  logic [ADDR_W-1:0] len_0,
   input  logic [DATA_W-1:0] seed_0,

   // engine 1 region
   input  logic [ADDR_W-1:0] base_1,
   input  logic [ADDR_W-1:0] len_1,
   input  logic [DATA_W-1:0] seed_1,

   output logic              done_0,
   output logic [ADDR_W-1:0] err_count_0,
   output logic              done_1,
   output logic [ADDR_W-1:0] err_count_1,

   // SRAM pins
   output logic [ADDR_W-1:0] sram_addr,
   output logic [DATA_W-1:0] sram_wr_data,
   input  logic [DATA_W-1:0] sram_rd_data,
   output logic              sram_tri_en,
   output logic              sram_we_bw
);

   sram_req_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) req_if_0 ();
   sram_req_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) req_if_1 ();

   sram_test_engine #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) u_engine_0 (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .base      (base_0),
      .len       (len_0),
      .seed      (seed_0),
      .bus       (req_if_0.requester),
      .done      (done_0),
      .err_count (err_count_0)
   );

   sram_test_engine #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) u_engine_1 (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .base      (base_1),
      .len       (len_1),
      .seed      (seed_1),
      .bus       (req_if_1.requester),
      .done      (done_1),
      .err_count (err_count_1)
   );

   sram_port_arbiter #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) u_arbiter (
      .clk          (clk),
      .reset        (reset),
      .port0        (req_if_0.server),   // port 0 wins the first poll
      .port1        (req_if_1.server),
      .sram_addr    (sram_addr),
      .sram_wr_data (sram_wr_data),
      .sram_rd_data (sram_rd_data),
      .sram_tri_en  (sram_tri_en),
      .sram_we_bw   (sram_we_bw)
   );

endmodule

// File: tb/sram_sync_model.sv
////////////////////////////////////////////////////////////////////////////
// behavioral synchronous SRAM, two clocks from address to read data
// write data is taken with tri_en two clocks after a we_bw-low address
// one address can be set to flip bit 0 of the data written there
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_sync_model #(
   parameter int ADDR_W = 19,
   parameter int DATA_W = 36
) (
   input  logic              clk,
   input  logic              reset,
   input  logic [ADDR_W-1:0] sram_addr,
   input  logic [DATA_W-1:0] sram_wr_data,
   output logic [DATA_W-1:0] sram_rd_data,
   input  logic              sram_tri_en,
   input  logic              sram_we_bw,
   input  logic              fault_en,
   input  logic [ADDR_W-1:0] fault_addr
);

   logic [DATA_W-1:0] mem [0:(1 << ADDR_W) - 1];

   logic [ADDR_W-1:0] addr_q;    // address seen one clock ago
   logic [ADDR_W-1:0] addr_qq;   // address seen two clocks ago
   logic              we_q;
   logic              we_qq;
   logic              fault_hit;

   assign fault_hit = fault_en && (addr_qq == fault_addr);

   always_ff @(posedge clk) begin
      if (reset) begin
         addr_q       <= '0;
         addr_qq      <= '0;
         we_q         <= 1'b0;
         we_qq        <= 1'b0;
         sram_rd_data <= '0;
      end else begin
         addr_q       <= sram_addr;
         addr_qq      <= addr_q;
         we_q         <= ~sram_we_bw;
         we_qq        <= we_q;
         sram_rd_data <= mem[addr_q];  // data two clocks after the address
         if (sram_tri_en && we_qq)
            mem[addr_qq] <= sram_wr_data ^ DATA_W'(fault_hit);
      end
   end

endmodule

// File: tb/sram_arbiter_assert.sv
////////////////////////////////////////////////////////////////////////////
// protocol checks on the SRAM port controller, bound into every instance
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_arbiter_assert (
   input logic clk,
   input logic reset,
   input logic ack_0,
   input logic ack_1,
   input logic sram_tri_en,
   input logic sram_we_bw
);

   // only one port is served at a time
   a_ack_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(ack_0 && ack_1))
      else $error("ack high on both ports in the same cycle");

   a_ack_0_pulse: assert property (@(posedge clk) disable iff (reset)
      ack_0 |=> !ack_0)
      else $error("ack on port 0 lasted more than one cycle");

   a_ack_1_pulse: assert property (@(posedge clk) disable iff (reset)
      ack_1 |=> !ack_1)
      else $error("ack on port 1 lasted more than one cycle");

   a_tri_en_pulse: assert property (@(posedge clk) disable iff (reset)
      sram_tri_en |=> !sram_tri_en)
      else $error("sram_tri_en high in two consecutive cycles");

   // write data goes out two clocks after the write address
   a_write_data_slot: assert property (@(posedge clk) disable iff (reset)
      !sram_we_bw |-> ##2 sram_tri_en)
      else $error("no sram_tri_en two cycles after a write address");

endmodule

bind sram_port_arbiter sram_arbiter_assert u_arbiter_assert (
   .clk         (clk),
   .reset       (reset),
   .ack_0       (port0.ack),
   .ack_1       (port1.ack),
   .sram_tri_en (sram_tri_en),
   .sram_we_bw  (sram_we_bw)
);

// File: tb/tb_sram_selftest.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the SRAM self-test top level
// runs a table of engine regions and fault settings against the SRAM
// model, checks error counts and the model's memory after each run
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_sram_selftest;

   localparam int ADDR_W = 19;
   localparam int DATA_W = 36;

   typedef struct {
      string name;
      int    base_0;
      int    len_0;
      int    base_1;
      int    len_1;
      bit    fault_en;
      int    fault_addr;
      int    exp_err_0;
      int    exp_err_1;
   } test_row_t;

   logic              clk;
   logic              reset;
   logic              start;
   logic [ADDR_W-1:0] base_0, len_0, base_1, len_1;
   logic [DATA_W-1:0] seed_0, seed_1;
   logic              done_0, done_1;
   logic [ADDR_W-1:0] err_count_0, err_count_1;
   logic [ADDR_W-1:0] sram_addr;
   logic [DATA_W-1:0] sram_wr_data, sram_rd_data;
   logic              sram_tri_en, sram_we_bw;
   logic              fault_en;
   logic [ADDR_W-1:0] fault_addr;

   test_row_t tests[$];
   int        errors       = 0;
   int        limit_cycles = 0;

   sram_selftest_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_dut (
      .clk (clk), .reset (reset), .start (start),
      .base_0 (base_0), .len_0 (len_0), .seed_0 (seed_0),
      .base_1 (base_1), .len_1 (len_1), .seed_1 (seed_1),
      .done_0 (done_0), .err_count_0 (err_count_0),
      .done_1 (done_1), .err_count_1 (err_count_1),
      .sram_addr (sram_addr), .sram_wr_data (sram_wr_data),
      .sram_rd_data (sram_rd_data), .sram_tri_en (sram_tri_en),
      .sram_we_bw (sram_we_bw)
   );

   sram_sync_model #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_sram (
      .clk (clk), .reset (reset),
      .sram_addr (sram_addr), .sram_wr_data (sram_wr_data),
      .sram_rd_data (sram_rd_data), .sram_tri_en (sram_tri_en),
      .sram_we_bw (sram_we_bw), .fault_en (fault_en), .fault_addr (fault_addr)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
         $display("Test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // model contents must be seed + address, with the fault bit flipped
   task automatic check_region(input string tag, input int base, input int len,
                               input logic [DATA_W-1:0] seed, input test_row_t row);
      logic [DATA_W-1:0] exp_word;
      int                a;
      for (int i = 0; i < len; i++) begin
         a        = base + i;
         exp_word = seed + DATA_W'(a);
         if (row.fault_en && a == row.fault_addr)
            exp_word[0] = ~exp_word[0];
         check_value($sformatf("%s mem[%0h]", tag, a), exp_word, u_sram.mem[a]);
      end
   endtask

   task automatic wait_done();
      @(negedge clk);
      while (!(done_0 && done_1))
         @(negedge clk);
   endtask

   task automatic build_table();
      //              name                  base_0 len_0 base_1   len_1 fault addr  e0 e1
      tests.push_back('{"single_engine_0",   'h100, 40, 'h800,    0,  0, 'h000,  0, 0});
      tests.push_back('{"dual_disjoint",     'h100, 32, 'h200,    32, 0, 'h000,  0, 0});
      tests.push_back('{"fault_in_region_0", 'h100, 32, 'h200,    32, 1, 'h10a,  1, 0});
      tests.push_back('{"fault_in_region_1", 'h100, 32, 'h200,    32, 1, 'h215,  0, 1});
      tests.push_back('{"restart_new_seeds", 'h100, 32, 'h200,    32, 0, 'h000,  0, 0});
      tests.push_back('{"fault_outside",     'h040, 24, 'h300,    16, 1, 'h400,  0, 0});
      tests.push_back('{"single_engine_1",   'h000, 0,  'h7fff0,  16, 0, 'h000,  0, 0});
   endtask

   // about 12 cycles per word pair on the bus, plus slack per row
   function automatic int run_limit();
      int total;
      total = 200;
      foreach (tests[i])
         total += 12 * (tests[i].len_0 + tests[i].len_1) + 100;
      return total;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // watchdog

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("timeout: engines did not finish within %0d cycles", limit_cycles);
      $display("Test failed");
      $fatal(1, "watchdog expired");
   end

   ////////////////////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      logic [31:0]       lcg_state;
      logic [DATA_W-1:0] row_seed_0;
      logic [DATA_W-1:0] row_seed_1;
      test_row_t         row;

      reset      = 1'b1;
      start      = 1'b0;
      base_0     = '0;
      len_0      = '0;
      seed_0     = '0;
      base_1     = '0;
      len_1      = '0;
      seed_1     = '0;
      fault_en   = 1'b0;
      fault_addr = '0;
      lcg_state  = 32'h56ac_78ae;

      build_table();
      limit_cycles = run_limit();

      repeat (2) @(posedge clk);
      reset <= 1'b0;

      foreach (tests[i]) begin
         row        = tests[i];
         lcg_state  = lcg_next(lcg_state);
         row_seed_0 = {lcg_state[31:28], lcg_state};
         lcg_state  = lcg_next(lcg_state);
         row_seed_1 = {lcg_state[31:28], lcg_state};

         @(posedge clk);
         base_0     <= ADDR_W'(row.base_0);
         len_0      <= ADDR_W'(row.len_0);
         seed_0     <= row_seed_0;
         base_1     <= ADDR_W'(row.base_1);
         len_1      <= ADDR_W'(row.len_1);
         seed_1     <= row_seed_1;
         fault_en   <= row.fault_en;
         fault_addr <= ADDR_W'(row.fault_addr);
         start      <= 1'b1;
         @(posedge clk);
         start      <= 1'b0;

         wait_done();
         check_value({row.name, " err_count_0"}, 64'(row.exp_err_0), 64'(err_count_0));
         check_value({row.name, " err_count_1"}, 64'(row.exp_err_1), 64'(err_count_1));
         check_region({row.name, " region_0"}, row.base_0, row.len_0, row_seed_0, row);
         check_region({row.name, " region_1"}, row.base_1, row.len_1, row_seed_1, row);
      end

      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: build.f
rtl/sram_pkg.sv
rtl/sram_req_if.sv
rtl/sram_port_arbiter.sv
rtl/sram_test_engine.sv
rtl/sram_selftest_top.sv
tb/sram_sync_model.sv
tb/sram_arbiter_assert.sv
tb/tb_sram_selftest.sv

// File: run.sh
#!/bin/sh
# builds the SRAM self-test simulation with Verilator and runs it
# the run passes only when the pass line shows up in sim.log

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module tb_sram_selftest > build.log 2>&1 \
   && ./obj_dir/Vtb_sram_selftest > sim.log 2>&1

grep -qx "Test completed successfully" sim.log && echo "PASS" && exit 0 \
   || { echo "FAIL, see build.log and sim.log"; exit 1; }
